//--- rtl/reducer_pkg.sv
`default_nettype none

package reducer_pkg;

  ////////////////////////////////////////////////////////////
  // widths and ratio
  ////////////////////////////////////////////////////////////

  localparam int DIN_WIDTH = 128;  // input word.
  localparam int DOUT_WIDTH = 32;  // output slice.

  // slices per wide word, whole numbers only.
  localparam int DATA_RATIO = DIN_WIDTH / DOUT_WIDTH;
  localparam int SLICE_IDX_WIDTH = 2;  // enough for DATA_RATIO slices.

  ////////////////////////////////////////////////////////////
  // input FIFO
  ////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH = 8;
  localparam int FIFO_ADDR_WIDTH = 3;
  localparam int RST_BUSY_CYCLES = 4;  // writes refused after reset.

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef logic [DIN_WIDTH-1:0] wide_word_t;
  typedef logic [DOUT_WIDTH-1:0] slice_t;
  typedef logic [SLICE_IDX_WIDTH-1:0] slice_idx_t;

  // EMPTY has no word, LAST shows the final slice of the held word.
  typedef enum logic [1:0] {
    EMPTY,
    HOLDING,
    LAST
  } reducer_state_t;

endpackage

`default_nettype wire

//--- rtl/wide_fifo_if.sv
`default_nettype none

interface wide_fifo_if;

  import reducer_pkg::*;

  wide_word_t wr_data;  // write side, from the top level.
  logic wr_en;

  logic rd_en;  // pop, from the reducer.

  wide_word_t rd_data;  // head word, fall-through.
  logic not_empty;
  logic full;
  logic rst_busy;

  modport fifo (
    input wr_data,
    input wr_en,
    input rd_en,
    output rd_data,
    output not_empty,
    output full,
    output rst_busy
  );

  modport user (
    input rd_data,
    input not_empty,
    output rd_en
  );

endinterface

`default_nettype wire

//--- rtl/wide_fifo.sv
`default_nettype none

module wide_fifo (
  input wire CLK,
  input wire RESETN,
  wide_fifo_if.fifo fifo_port
);

  import reducer_pkg::*;

  typedef logic [FIFO_ADDR_WIDTH-1:0] ptr_t;
  typedef logic [FIFO_ADDR_WIDTH:0] count_t;
  typedef logic [$clog2(RST_BUSY_CYCLES+1)-1:0] busy_cnt_t;

  wide_word_t mem [FIFO_DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  count_t count;
  busy_cnt_t busy_cnt;

  logic do_wr;
  logic do_rd;

  assign do_wr = fifo_port.wr_en;
  assign do_rd = fifo_port.rd_en;

  ////////////////////////////////////////////////////////////
  // status
  ////////////////////////////////////////////////////////////

  assign fifo_port.not_empty = (count != '0);
  assign fifo_port.full = (count == count_t'(FIFO_DEPTH));
  assign fifo_port.rst_busy = (busy_cnt != '0);

  // head word shows without a read cycle.
  assign fifo_port.rd_data = mem[rd_ptr];

  ////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= fifo_port.wr_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at FIFO_DEPTH.
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;  // idle or write and read together.
      endcase
    end
  end

  // held high through reset, then counts down.
  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      busy_cnt <= busy_cnt_t'(RST_BUSY_CYCLES);
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // the top level gates wr_en with in_ready.
  a_no_write_full: assert property (
    @(posedge CLK) disable iff (!RESETN)
    fifo_port.wr_en |-> !fifo_port.full && !fifo_port.rst_busy
  ) else $error("wide_fifo: write while full or busy");

  a_no_read_empty: assert property (
    @(posedge CLK) disable iff (!RESETN)
    fifo_port.rd_en |-> fifo_port.not_empty
  ) else $error("wide_fifo: read while empty");

endmodule

`default_nettype wire

//--- rtl/width_reducer.sv
`default_nettype none

module width_reducer (
  input wire CLK,
  input wire RESETN,
  wide_fifo_if.user fifo_port,
  output reducer_pkg::slice_t out_data,
  output logic out_valid,
  input wire out_ready
);

  import reducer_pkg::*;

  reducer_state_t state;
  wide_word_t word;  // word being sliced.
  slice_idx_t idx;

  logic pop;
  logic last_taken;
  logic slice_taken;

  ////////////////////////////////////////////////////////////
  // FIFO side
  ////////////////////////////////////////////////////////////

  assign slice_taken = out_valid && out_ready;
  assign last_taken = (state == LAST) && out_ready;

  // refill on the edge that takes the last slice, so no bubble.
  assign pop = fifo_port.not_empty && ((state == EMPTY) || last_taken);
  assign fifo_port.rd_en = pop;

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  assign out_valid = (state != EMPTY);
  assign out_data = word[idx * DOUT_WIDTH +: DOUT_WIDTH];  // lowest slice first.

  always_ff @(posedge CLK) begin
    if (pop) begin
      word <= fifo_port.rd_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RESETN) begin
      state <= EMPTY;
      idx <= '0;
    end else begin
      case (state)
        EMPTY: begin
          if (pop) begin
            state <= HOLDING;
            idx <= '0;
          end
        end
        HOLDING: begin
          if (slice_taken) begin
            idx <= idx + 1'b1;
            if (idx == slice_idx_t'(DATA_RATIO - 2)) begin
              state <= LAST;  // next slice is the final one.
            end
          end
        end
        LAST: begin
          if (last_taken) begin
            idx <= '0;
            if (pop) begin
              state <= HOLDING;
            end else begin
              state <= EMPTY;
            end
          end
        end
        default: begin
          state <= EMPTY;
          idx <= '0;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////

  // a stalled slice holds until the sink takes it.
  a_hold_stall: assert property (
    @(posedge CLK) disable iff (!RESETN)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("width_reducer: output changed under back-pressure");

  a_rd_not_empty: assert property (
    @(posedge CLK) disable iff (!RESETN)
    fifo_port.rd_en |-> fifo_port.not_empty
  ) else $error("width_reducer: pop from empty FIFO");

endmodule

`default_nettype wire

//--- rtl/reducer_top.sv
`default_nettype none

module reducer_top (
  input wire CLK,
  input wire RESETN,
  input wire reducer_pkg::wide_word_t in_data,
  input wire in_valid,
  output logic in_ready,
  output reducer_pkg::slice_t out_data,
  output logic out_valid,
  input wire out_ready
);

  wide_fifo_if fifo_bus ();

  ////////////////////////////////////////////////////////////
  // input side
  ////////////////////////////////////////////////////////////

  // low while full or still busy after reset.
  assign in_ready = !fifo_bus.full && !fifo_bus.rst_busy;

  assign fifo_bus.wr_data = in_data;
  assign fifo_bus.wr_en = in_valid && in_ready;  // only accepted words.

  wide_fifo i_wide_fifo (
    .CLK(CLK),
    .RESETN(RESETN),
    .fifo_port(fifo_bus.fifo)
  );

  ////////////////////////////////////////////////////////////
  // output side
  ////////////////////////////////////////////////////////////

  width_reducer i_width_reducer (
    .CLK(CLK),
    .RESETN(RESETN),
    .fifo_port(fifo_bus.user),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

endmodule

`default_nettype wire

//--- bench/reducer_tb.sv
`default_nettype none

module reducer_tb;

  import reducer_pkg::*;

  localparam int SEED = 32'h0c874574;
  localparam int WAIT_LIMIT = 1000;  // cycles per wait loop.

  logic CLK;
  logic RESETN;
  wide_word_t in_data;
  logic in_valid;
  logic in_ready;
  slice_t out_data;
  logic out_valid;
  logic out_ready;

  // reference model state.
  slice_t exp_q[$];
  slice_t exp_head = '0;
  int exp_count = 0;
  int acc_words = 0;
  int out_slices = 0;

  string test_name = "none";
  int errors = 0;
  int errors_at_start = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int fill_count;

  reducer_top i_reducer_top (
    .CLK(CLK),
    .RESETN(RESETN),
    .in_data(in_data),
    .in_valid(in_valid),
    .in_ready(in_ready),
    .out_data(out_data),
    .out_valid(out_valid),
    .out_ready(out_ready)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (!RESETN) begin
      exp_q.delete();
    end else begin
      if (out_valid && out_ready) begin
        out_slices++;
        if (exp_q.size() > 0) begin
          void'(exp_q.pop_front());
        end
      end
      if (in_valid && in_ready) begin
        acc_words++;
        for (int i = 0; i < DATA_RATIO; i++) begin
          exp_q.push_back(slice_t'(in_data >> (i * DOUT_WIDTH)));  // lowest first.
        end
      end
    end
    exp_count <= exp_q.size();
    exp_head <= (exp_q.size() > 0) ? exp_q[0] : '0;
  end

  ////////////////////////////////////////////////////////////
  // output checks
  ////////////////////////////////////////////////////////////

  slice_check: assert property (
    @(posedge CLK) disable iff (!RESETN)
    out_valid && out_ready |-> exp_count > 0 && out_data == exp_head
  ) else begin
    errors++;
    if ($sampled(exp_count) == 0) begin
      $display("test %s: slice sent with no slice expected", test_name);
    end else begin
      $display("mismatch %s: expected %h, actual %h", test_name,
               $sampled(exp_head), $sampled(out_data));
    end
  end

  hold_check: assert property (
    @(posedge CLK) disable iff (!RESETN)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else begin
    errors++;
    $display("test %s: output moved while stalled", test_name);
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic wide_word_t rand_word();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - errors_at_start);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("test %s: timed out waiting for %s", test_name, what);
  endtask

  task automatic apply_reset();
    int cycles;
    RESETN = 1'b0;
    for (int i = 0; i < 4; i++) begin
      @(negedge CLK);
      assert (!out_valid && !in_ready) else begin
        errors++;
        $display("test %s: out_valid or in_ready high during reset", test_name);
      end
    end
    RESETN = 1'b1;
    @(negedge CLK);
    cycles = 1;
    assert (!out_valid && !in_ready) else begin
      errors++;
      $display("test %s: out_valid or in_ready high just after reset", test_name);
    end
    while (!in_ready && cycles < RST_BUSY_CYCLES + 2) begin
      @(negedge CLK);
      cycles++;
    end
    assert (in_ready) else begin
      errors++;
      $display("test %s: in_ready did not rise after reset", test_name);
    end
  endtask

  task automatic send_words(input int count, input bit rand_valid, input bit rand_ready);
    int target;
    int cycles;
    target = acc_words + count;
    cycles = 0;
    while (acc_words < target) begin
      if (cycles >= WAIT_LIMIT) begin
        report_timeout("input words to be accepted");
        break;
      end
      in_valid = rand_valid ? (($urandom() % 2) != 0) : 1'b1;
      in_data = rand_word();
      if (rand_ready) begin
        out_ready = ($urandom() % 2) != 0;
      end
      @(negedge CLK);
      cycles++;
    end
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    out_ready = 1'b1;
    while (exp_count != 0 || out_valid) begin
      if (cycles >= WAIT_LIMIT) begin
        report_timeout("the output to drain");
        break;
      end
      @(negedge CLK);
      cycles++;
    end
    assert (out_slices == acc_words * DATA_RATIO) else begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", test_name,
               acc_words * DATA_RATIO, out_slices);
    end
  endtask

  // offer words with the sink stalled until in_ready falls.
  task automatic fill_fifo(output int accepted);
    int start;
    int cycles;
    start = acc_words;
    cycles = 0;
    out_ready = 1'b0;
    while (in_ready) begin
      if (cycles >= WAIT_LIMIT) begin
        report_timeout("in_ready to fall");
        break;
      end
      in_valid = 1'b1;
      in_data = rand_word();
      @(negedge CLK);
      cycles++;
    end
    in_valid = 1'b0;
    accepted = acc_words - start;
    assert (accepted == FIFO_DEPTH + 1) else begin
      errors++;
      $display("mismatch %s: expected %0d, actual %0d", test_name, FIFO_DEPTH + 1, accepted);
    end
  endtask

  task automatic check_stream(input int words);
    int target;
    int cycles;
    target = out_slices + words * DATA_RATIO;
    cycles = 0;
    out_ready = 1'b1;
    while (out_slices < target) begin
      if (cycles >= WAIT_LIMIT) begin
        report_timeout("the stream to finish");
        break;
      end
      assert (out_valid) else begin
        errors++;
        $display("test %s: bubble in the output stream", test_name);
      end
      @(negedge CLK);
      cycles++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    RESETN = 1'b0;
    in_data = '0;
    in_valid = 1'b0;
    out_ready = 1'b0;

    begin_test("reset");
    apply_reset();
    end_test();

    begin_test("slice_order");
    out_ready = 1'b1;
    send_words(20, 1'b0, 1'b0);
    wait_drained();
    end_test();

    begin_test("back_pressure");
    send_words(30, 1'b1, 1'b1);
    wait_drained();
    end_test();

    begin_test("fill");
    fill_fifo(fill_count);
    wait_drained();
    end_test();

    begin_test("streaming");
    fill_fifo(fill_count);
    check_stream(fill_count);
    wait_drained();
    end_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
rtl/reducer_pkg.sv
rtl/wide_fifo_if.sv
rtl/wide_fifo.sv
rtl/width_reducer.sv
rtl/reducer_top.sv
bench/reducer_tb.sv

//--- run.sh
#!/bin/sh
# Build with Verilator, run, then search the log for the fail message.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module reducer_tb -f compile.f -o reducer_sim \
  && ./obj_dir/reducer_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0
